// ==== logic/bus_types_pkg.sv ====
package bus_types_pkg;

    // bus geometry
    localparam int XLEN   = 32;
    localparam int DATA_W = 32;

    // full byte address as issued by the master
    typedef logic [XLEN-1:0] addr_t;

    // one bus data word, read or write
    typedef logic [DATA_W-1:0] data_t;

    // access size, shared by master and all targets
    typedef enum logic [1:0] {
        acc_1b = 2'd0, // byte
        acc_2b = 2'd1, // halfword
        acc_4b = 2'd2  // word
    } acc_t;

endpackage

// ==== logic/bus_map_pkg.sv ====
package bus_map_pkg;

    import bus_types_pkg::*;

    // targets on the fabric
    typedef enum logic [1:0] {
        dev_rom  = 2'd0,
        dev_tcm  = 2'd1,
        dev_sram = 2'd2,
        dev_gpio = 2'd3
    } dev_t;

    // byte address widths of the windows
    localparam int ROM_ABW  = 12;
    localparam int TCM_ABW  = 12;
    localparam int SRAM_ABW = 19;

    typedef logic [ROM_ABW-1:0]  rom_addr_t;
    typedef logic [TCM_ABW-1:0]  tcm_addr_t;
    typedef logic [SRAM_ABW-1:0] sram_addr_t;
    typedef logic [0:0]          gpio_addr_t; // two registers, 0x0 and 0x4

    // window bases
    localparam addr_t ROM_BASE  = 32'h0000_0000;
    localparam addr_t TCM_BASE  = 32'h1000_0000;
    localparam addr_t SRAM_BASE = 32'h2000_0000;
    localparam addr_t GPIO_BASE = 32'h4000_0000; // only 0x4000_0000 and 0x4000_0004

endpackage

// ==== logic/bus_decode_if.sv ====
interface bus_decode_if import bus_map_pkg::*; ();

    dev_t dev_sel;  // target picked by the address
    logic addr_hit; // address falls in some window
    logic aligned;  // size fits low address bits

    modport decoder (
        output dev_sel,
        output addr_hit,
        output aligned
    );

    modport dispatch (
        input dev_sel,
        input addr_hit,
        input aligned
    );

endinterface

// ==== logic/bus_addr_decode.sv ====
module bus_addr_decode import bus_types_pkg::*, bus_map_pkg::*; (
    input  addr_t                bus_addr,
    input  acc_t                 bus_acc,
    bus_decode_if.decoder        dec
);

    logic rom_hit;
    logic tcm_hit;
    logic sram_hit;
    logic gpio_hit;

    assign rom_hit  = bus_addr[XLEN-1:ROM_ABW]  == ROM_BASE[XLEN-1:ROM_ABW];
    assign tcm_hit  = bus_addr[XLEN-1:TCM_ABW]  == TCM_BASE[XLEN-1:TCM_ABW];
    assign sram_hit = bus_addr[XLEN-1:SRAM_ABW] == SRAM_BASE[XLEN-1:SRAM_ABW];

    // gpio holds two word registers only
    assign gpio_hit = (bus_addr[XLEN-1:3] == GPIO_BASE[XLEN-1:3]) && (bus_addr[1:0] == 2'b00);

    always_comb begin
        dec.addr_hit = 1'b1;
        if (rom_hit) begin
            dec.dev_sel = dev_rom;
        end else if (tcm_hit) begin
            dec.dev_sel = dev_tcm;
        end else if (sram_hit) begin
            dec.dev_sel = dev_sram;
        end else if (gpio_hit) begin
            dec.dev_sel = dev_gpio;
        end else begin
            dec.dev_sel  = dev_rom; // don't care on a miss
            dec.addr_hit = 1'b0;
        end
    end

    always_comb begin
        case (bus_acc)
            acc_2b:  dec.aligned = ~bus_addr[0];
            acc_4b:  dec.aligned = (bus_addr[1:0] == 2'b00);
            default: dec.aligned = 1'b1; // bytes are always aligned
        endcase
    end

endmodule

// ==== logic/bus_dispatch.sv ====
module bus_dispatch import bus_types_pkg::*, bus_map_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    bus_decode_if.dispatch       dec,

    input  logic                 bus_req,
    input  addr_t                bus_addr,
    input  logic                 bus_wr_b,
    input  acc_t                 bus_acc,
    input  data_t                bus_wdata,

    input  logic                 rom_fault,
    input  logic                 tcm_fault,
    input  logic                 sram_fault,
    input  logic                 gpio_fault,

    output rom_addr_t            rom_addr,
    output logic                 rom_wr_b,
    output acc_t                 rom_acc,
    output data_t                rom_wdata,
    output logic                 rom_req,

    output tcm_addr_t            tcm_addr,
    output logic                 tcm_wr_b,
    output acc_t                 tcm_acc,
    output data_t                tcm_wdata,
    output logic                 tcm_req,

    output sram_addr_t           sram_addr,
    output logic                 sram_wr_b,
    output acc_t                 sram_acc,
    output data_t                sram_wdata,
    output logic                 sram_req,

    output gpio_addr_t           gpio_addr,
    output logic                 gpio_wr_b,
    output acc_t                 gpio_acc,
    output data_t                gpio_wdata,
    output logic                 gpio_req,

    output logic                 issue,
    output dev_t                 issue_dev,

    output logic                 fault,
    output addr_t                fault_addr
);

    logic legal;
    logic violation;
    logic tgt_fault;
    logic set_fault;

    assign legal     = dec.addr_hit & dec.aligned;
    assign issue     = bus_req & legal & ~fault; // nothing new once faulted
    assign issue_dev = dec.dev_sel;

    assign rom_req  = issue && (dec.dev_sel == dev_rom);
    assign tcm_req  = issue && (dec.dev_sel == dev_tcm);
    assign sram_req = issue && (dec.dev_sel == dev_sram);
    assign gpio_req = issue && (dec.dev_sel == dev_gpio);

    // window offsets
    assign rom_addr  = bus_addr[ROM_ABW-1:0];
    assign tcm_addr  = bus_addr[TCM_ABW-1:0];
    assign sram_addr = bus_addr[SRAM_ABW-1:0];
    assign gpio_addr = bus_addr[2]; // word select

    assign {rom_wr_b, tcm_wr_b, sram_wr_b, gpio_wr_b} = {4{bus_wr_b}};
    assign {rom_acc, tcm_acc, sram_acc, gpio_acc}     = {4{bus_acc}};
    assign rom_wdata  = bus_wdata;
    assign tcm_wdata  = bus_wdata;
    assign sram_wdata = bus_wdata;
    assign gpio_wdata = bus_wdata;

    assign violation = bus_req & ~legal;
    assign tgt_fault = rom_fault | tcm_fault | sram_fault | gpio_fault;
    assign set_fault = ~fault & (violation | tgt_fault); // first event only

    always_ff @(posedge clk) begin
        if (!rstn) begin
            fault <= 1'b0;
        end else if (set_fault) begin
            fault <= 1'b1; // sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        if (set_fault) begin
            fault_addr <= bus_addr;
        end
    end

endmodule

// ==== logic/bus_response.sv ====
module bus_response import bus_types_pkg::*, bus_map_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,

    input  logic                 issue,
    input  dev_t                 issue_dev,

    input  data_t                rom_rdata,
    input  data_t                tcm_rdata,
    input  data_t                sram_rdata,
    input  data_t                gpio_rdata,
    input  logic                 rom_resp,
    input  logic                 tcm_resp,
    input  logic                 sram_resp,
    input  logic                 gpio_resp,

    output data_t                bus_rdata,
    output logic                 bus_resp
);

    logic pending;  // one request in flight
    dev_t out_dev;  // target owing the response
    logic sel_resp;

    always_comb begin
        case (out_dev)
            dev_rom:  {sel_resp, bus_rdata} = {rom_resp, rom_rdata};
            dev_tcm:  {sel_resp, bus_rdata} = {tcm_resp, tcm_rdata};
            dev_sram: {sel_resp, bus_rdata} = {sram_resp, sram_rdata};
            default:  {sel_resp, bus_rdata} = {gpio_resp, gpio_rdata};
        endcase
    end

    assign bus_resp = pending & sel_resp; // stray responses dropped

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pending <= 1'b0;
        end else if (issue) begin
            pending <= 1'b1;
        end else if (bus_resp) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            out_dev <= issue_dev;
        end
    end

endmodule

// ==== logic/bus_fabric.sv ====
module bus_fabric import bus_types_pkg::*, bus_map_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,

    input  logic                 bus_req,
    input  addr_t                bus_addr,
    input  logic                 bus_wr_b,
    input  acc_t                 bus_acc,
    input  data_t                bus_wdata,
    output data_t                bus_rdata,
    output logic                 bus_resp,

    output logic                 fault,
    output addr_t                fault_addr,

    output rom_addr_t            rom_addr,
    output logic                 rom_wr_b,
    output acc_t                 rom_acc,
    output data_t                rom_wdata,
    output logic                 rom_req,
    input  data_t                rom_rdata,
    input  logic                 rom_resp,
    input  logic                 rom_fault,

    output tcm_addr_t            tcm_addr,
    output logic                 tcm_wr_b,
    output acc_t                 tcm_acc,
    output data_t                tcm_wdata,
    output logic                 tcm_req,
    input  data_t                tcm_rdata,
    input  logic                 tcm_resp,
    input  logic                 tcm_fault,

    output sram_addr_t           sram_addr,
    output logic                 sram_wr_b,
    output acc_t                 sram_acc,
    output data_t                sram_wdata,
    output logic                 sram_req,
    input  data_t                sram_rdata,
    input  logic                 sram_resp,
    input  logic                 sram_fault,

    output gpio_addr_t           gpio_addr,
    output logic                 gpio_wr_b,
    output acc_t                 gpio_acc,
    output data_t                gpio_wdata,
    output logic                 gpio_req,
    input  data_t                gpio_rdata,
    input  logic                 gpio_resp,
    input  logic                 gpio_fault
);

    bus_decode_if dec_if ();

    logic issue;
    dev_t issue_dev;

    bus_addr_decode u_decode (
        .bus_addr (bus_addr),
        .bus_acc  (bus_acc),
        .dec      (dec_if.decoder)
    );

    bus_dispatch u_dispatch (
        .clk        (clk),
        .rstn       (rstn),
        .dec        (dec_if.dispatch),
        .bus_req    (bus_req),
        .bus_addr   (bus_addr),
        .bus_wr_b   (bus_wr_b),
        .bus_acc    (bus_acc),
        .bus_wdata  (bus_wdata),
        .rom_fault  (rom_fault),
        .tcm_fault  (tcm_fault),
        .sram_fault (sram_fault),
        .gpio_fault (gpio_fault),
        .rom_addr   (rom_addr),
        .rom_wr_b   (rom_wr_b),
        .rom_acc    (rom_acc),
        .rom_wdata  (rom_wdata),
        .rom_req    (rom_req),
        .tcm_addr   (tcm_addr),
        .tcm_wr_b   (tcm_wr_b),
        .tcm_acc    (tcm_acc),
        .tcm_wdata  (tcm_wdata),
        .tcm_req    (tcm_req),
        .sram_addr  (sram_addr),
        .sram_wr_b  (sram_wr_b),
        .sram_acc   (sram_acc),
        .sram_wdata (sram_wdata),
        .sram_req   (sram_req),
        .gpio_addr  (gpio_addr),
        .gpio_wr_b  (gpio_wr_b),
        .gpio_acc   (gpio_acc),
        .gpio_wdata (gpio_wdata),
        .gpio_req   (gpio_req),
        .issue      (issue),
        .issue_dev  (issue_dev),
        .fault      (fault),
        .fault_addr (fault_addr)
    );

    bus_response u_response (
        .clk        (clk),
        .rstn       (rstn),
        .issue      (issue),
        .issue_dev  (issue_dev),
        .rom_rdata  (rom_rdata),
        .tcm_rdata  (tcm_rdata),
        .sram_rdata (sram_rdata),
        .gpio_rdata (gpio_rdata),
        .rom_resp   (rom_resp),
        .tcm_resp   (tcm_resp),
        .sram_resp  (sram_resp),
        .gpio_resp  (gpio_resp),
        .bus_rdata  (bus_rdata),
        .bus_resp   (bus_resp)
    );

endmodule

// ==== verif/bus_fabric_asserts.sv ====
module bus_fabric_asserts (
    input  logic clk,
    input  logic rstn,
    input  logic rom_req,
    input  logic tcm_req,
    input  logic sram_req,
    input  logic gpio_req,
    input  logic fault
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    logic [3:0] reqs;

    assign reqs = {gpio_req, sram_req, tcm_req, rom_req};

    one_target: assert property (@(posedge clk) disable iff (!rstn) $onehot0(reqs))
        else begin
            fail_count++;
            $error("more than one target request in one cycle");
        end

    quiet_on_fault: assert property (@(posedge clk) disable iff (!rstn) fault |-> (reqs == 4'b0))
        else begin
            fail_count++;
            $error("target request issued while fault is held");
        end

    fault_sticky: assert property (@(posedge clk) disable iff (!rstn) fault |=> fault)
        else begin
            fail_count++;
            $error("fault dropped without reset");
        end

endmodule

bind bus_dispatch bus_fabric_asserts u_asserts (
    .clk      (clk),
    .rstn     (rstn),
    .rom_req  (rom_req),
    .tcm_req  (tcm_req),
    .sram_req (sram_req),
    .gpio_req (gpio_req),
    .fault    (fault)
);

// ==== verif/bus_fabric_checker.sv ====
module bus_fabric_checker import bus_types_pkg::*, bus_map_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic            bus_req,
    input  addr_t           bus_addr,
    input  logic            bus_wr_b,
    input  acc_t            bus_acc,
    input  data_t           bus_wdata,
    input  logic            bus_resp,
    input  data_t           bus_rdata,
    input  logic            fault,
    input  addr_t           fault_addr,
    input  logic [3:0]      x_req,   // indexed by dev_t
    input  addr_t [3:0]     x_off,   // window offset, zero extended
    input  logic [3:0]      x_wr_b,
    input  logic [3:0][1:0] x_acc,
    input  data_t [3:0]     x_wdata,
    input  int              exp_idx,
    input  logic            exp_ok,
    input  dev_t            exp_dev,
    input  logic            exp_tgt_err,
    output int              err_count,
    output int              done_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic  rstn_q;
    logic  busy;        // routed request waiting for bus_resp
    logic  fault_due;   // fault must show at this edge
    logic  ff_valid;
    addr_t ff_addr;     // first faulting address since reset
    addr_t req_addr;
    dev_t  req_dev;
    logic  req_wr_b;
    logic  req_tgt_err;
    int    req_idx;
    int    entry_errs;

    initial begin
        err_count  = 0;
        done_count = 0;
        entry_errs = 0;
    end

    function automatic addr_t base_of(input dev_t d);
        case (d)
            dev_rom:  return ROM_BASE;
            dev_tcm:  return TCM_BASE;
            dev_sram: return SRAM_BASE;
            default:  return GPIO_BASE;
        endcase
    endfunction

    // target readback pattern, base xor offset
    function automatic data_t expect_rdata(input addr_t a, input dev_t d);
        return base_of(d) ^ (a - base_of(d));
    endfunction

    task automatic check_value(input string name, input logic [31:0] want, input logic [31:0] got);
        if (got !== want) begin
            $display("[ERROR] %0d ns %s expected %h actual %h", $time, name, want, got);
            err_count++;
            entry_errs++;
        end
    endtask

    task automatic finish_entry();
        $display("entry %0d at %0d ns: %s", req_idx, $time, (entry_errs == 0) ? "pass" : "FAIL");
        done_count++;
        entry_errs = 0;
    endtask

    always @(posedge clk) begin
        rstn_q <= rstn;
        if (!rstn) begin
            busy      <= 1'b0;
            fault_due <= 1'b0;
            ff_valid  <= 1'b0;
        end else begin
            if (!rstn_q) begin // first edge out of reset
                check_value("fault", 32'd0, fault);
                check_value("x_req", 32'd0, x_req);
                check_value("bus_resp", 32'd0, bus_resp);
            end
            if (fault_due) begin
                check_value("fault", 32'd1, fault);
                check_value("fault_addr", ff_addr, fault_addr);
                fault_due <= 1'b0;
                finish_entry();
            end
            if (bus_resp) begin
                if (!busy) begin
                    $display("%0d ns: bus_resp arrived with no request outstanding", $time);
                    err_count++;
                end else begin
                    if (req_wr_b) begin
                        check_value("bus_rdata", expect_rdata(req_addr, req_dev), bus_rdata);
                    end
                    busy <= 1'b0;
                    if (req_tgt_err) begin
                        fault_due <= 1'b1;
                        if (!ff_valid) begin
                            ff_valid <= 1'b1;
                            ff_addr  <= req_addr;
                        end
                    end else begin
                        finish_entry();
                    end
                end
            end
            if (bus_req) begin
                req_addr    <= bus_addr;
                req_dev     <= exp_dev;
                req_wr_b    <= bus_wr_b;
                req_tgt_err <= exp_tgt_err;
                req_idx     <= exp_idx;
                if (exp_ok || exp_tgt_err) begin
                    check_value("x_req", 4'b0001 << exp_dev, x_req);
                    check_value("x_addr", bus_addr - base_of(exp_dev), x_off[exp_dev]);
                    check_value("x_wr_b", bus_wr_b, x_wr_b[exp_dev]);
                    check_value("x_acc", bus_acc, x_acc[exp_dev]);
                    check_value("x_wdata", bus_wdata, x_wdata[exp_dev]);
                    busy <= 1'b1;
                end else begin
                    check_value("x_req", 32'd0, x_req);
                    fault_due <= 1'b1;
                    if (!ff_valid) begin
                        ff_valid <= 1'b1;
                        ff_addr  <= bus_addr;
                    end
                end
            end
        end
    end

endmodule

// ==== verif/bus_fabric_tb.sv ====
module bus_fabric_tb import bus_types_pkg::*, bus_map_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ENTRY = 14;

    typedef enum logic {
        res_ok,
        res_fault
    } outcome_t;

    typedef struct packed {
        addr_t    addr;
        logic     wr_b;
        acc_t     acc;
        data_t    wdata;
        outcome_t outcome;
        dev_t     dev;
        logic     tgt_err; // target answers with a fault
        logic     pre_rst;
    } entry_t;

    logic clk = 1'b0;
    logic rstn;
    logic bus_req;
    addr_t bus_addr;
    logic bus_wr_b;
    acc_t bus_acc;
    data_t bus_wdata;
    data_t bus_rdata;
    logic bus_resp;
    logic fault;
    addr_t fault_addr;
    rom_addr_t rom_addr;
    tcm_addr_t tcm_addr;
    sram_addr_t sram_addr;
    gpio_addr_t gpio_addr;
    logic rom_wr_b, tcm_wr_b, sram_wr_b, gpio_wr_b;
    logic rom_req, tcm_req, sram_req, gpio_req;
    logic rom_resp, tcm_resp, sram_resp, gpio_resp;
    logic rom_fault, tcm_fault, sram_fault, gpio_fault;
    acc_t rom_acc, tcm_acc, sram_acc, gpio_acc;
    data_t rom_wdata, tcm_wdata, sram_wdata, gpio_wdata;
    data_t rom_rdata, tcm_rdata, sram_rdata, gpio_rdata;

    entry_t tbl [N_ENTRY];
    int     n_fill = 0;
    int     rsp_delay;
    logic   tgt_err_drv;
    int     exp_idx;
    logic   exp_ok;
    dev_t   exp_dev;
    logic   exp_tgt_err;
    int     err_count;
    int     done_count;
    int     total_err;

    always #4 clk = ~clk;

    bus_fabric uut (.*);

    target_model #(.BASE(ROM_BASE)) u_rom (
        .clk, .rstn, .delay(rsp_delay), .raise_fault(tgt_err_drv),
        .req(rom_req), .offset({20'd0, rom_addr}),
        .rdata(rom_rdata), .resp(rom_resp), .fault(rom_fault)
    );
    target_model #(.BASE(TCM_BASE)) u_tcm (
        .clk, .rstn, .delay(rsp_delay), .raise_fault(tgt_err_drv),
        .req(tcm_req), .offset({20'd0, tcm_addr}),
        .rdata(tcm_rdata), .resp(tcm_resp), .fault(tcm_fault)
    );
    target_model #(.BASE(SRAM_BASE)) u_sram (
        .clk, .rstn, .delay(rsp_delay), .raise_fault(tgt_err_drv),
        .req(sram_req), .offset({13'd0, sram_addr}),
        .rdata(sram_rdata), .resp(sram_resp), .fault(sram_fault)
    );
    target_model #(.BASE(GPIO_BASE)) u_gpio (
        .clk, .rstn, .delay(rsp_delay), .raise_fault(tgt_err_drv),
        .req(gpio_req), .offset({29'd0, gpio_addr, 2'b00}),
        .rdata(gpio_rdata), .resp(gpio_resp), .fault(gpio_fault)
    );

    bus_fabric_checker u_check (
        .clk, .rstn, .bus_req, .bus_addr, .bus_wr_b, .bus_acc, .bus_wdata,
        .bus_resp, .bus_rdata, .fault, .fault_addr,
        .x_req   ({gpio_req, sram_req, tcm_req, rom_req}),
        .x_off   ({{29'd0, gpio_addr, 2'b00}, {13'd0, sram_addr},
                   {20'd0, tcm_addr}, {20'd0, rom_addr}}),
        .x_wr_b  ({gpio_wr_b, sram_wr_b, tcm_wr_b, rom_wr_b}),
        .x_acc   ({gpio_acc, sram_acc, tcm_acc, rom_acc}),
        .x_wdata ({gpio_wdata, sram_wdata, tcm_wdata, rom_wdata}),
        .exp_idx, .exp_ok, .exp_dev, .exp_tgt_err,
        .err_count, .done_count
    );

    task automatic add_entry(input addr_t a, input logic w, input acc_t s, input data_t d,
                             input outcome_t o, input dev_t t, input logic te, input logic r);
        tbl[n_fill] = '{a, w, s, d, o, t, te, r};
        n_fill++;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rstn = 1'b0;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
    endtask

    task automatic run_entry(input int idx);
        entry_t e;
        e = tbl[idx];
        if (e.pre_rst) begin
            apply_reset();
        end
        @(negedge clk);
        bus_addr    = e.addr;
        bus_wr_b    = e.wr_b;
        bus_acc     = e.acc;
        bus_wdata   = e.wdata;
        bus_req     = 1'b1;
        exp_idx     = idx;
        exp_ok      = (e.outcome == res_ok);
        exp_dev     = e.dev;
        exp_tgt_err = e.tgt_err;
        tgt_err_drv = e.tgt_err;
        rsp_delay   = 1 + ($urandom % 3);
        @(negedge clk);
        bus_req = 1'b0;
        if (exp_ok || e.tgt_err) begin
            do begin
                @(posedge clk);
            end while (!bus_resp);
        end else begin
            do begin
                @(posedge clk);
            end while (!fault);
        end
        repeat (2) @(negedge clk); // let the checker close the entry
    endtask

    initial begin
        void'($urandom(32'hd79a));
        rstn        = 1'b0;
        bus_req     = 1'b0;
        bus_addr    = '0;
        bus_wr_b    = 1'b1;
        bus_acc     = acc_1b;
        bus_wdata   = '0;
        rsp_delay   = 1;
        tgt_err_drv = 1'b0;
        exp_idx     = 0;
        exp_ok      = 1'b1;
        exp_dev     = dev_rom;
        exp_tgt_err = 1'b0;
        // wr_b high is a read
        add_entry(32'h0000_0124, 1'b1, acc_4b, 32'h0000_0000, res_ok, dev_rom, 1'b0, 1'b1);
        add_entry(32'h1000_0ffc, 1'b0, acc_4b, 32'ha5a5_0001, res_ok, dev_tcm, 1'b0, 1'b0);
        add_entry(32'h2007_fff0, 1'b1, acc_4b, 32'h0000_0000, res_ok, dev_sram, 1'b0, 1'b0);
        add_entry(32'h2000_1231, 1'b0, acc_1b, 32'h0000_005c, res_ok, dev_sram, 1'b0, 1'b0);
        add_entry(32'h4000_0004, 1'b1, acc_4b, 32'h0000_0000, res_ok, dev_gpio, 1'b0, 1'b0);
        add_entry(32'h4000_0000, 1'b0, acc_2b, 32'h0000_beef, res_ok, dev_gpio, 1'b0, 1'b0);
        add_entry(32'h1000_0002, 1'b1, acc_2b, 32'h0000_0000, res_ok, dev_tcm, 1'b0, 1'b0);
        add_entry(32'h6000_0000, 1'b1, acc_4b, 32'h0000_0000, res_fault, dev_rom, 1'b0, 1'b0);
        add_entry(32'h4000_0008, 1'b1, acc_4b, 32'h0000_0000, res_fault, dev_rom, 1'b0, 1'b1);
        add_entry(32'h2000_0102, 1'b1, acc_4b, 32'h0000_0000, res_fault, dev_rom, 1'b0, 1'b1);
        add_entry(32'h1000_0013, 1'b0, acc_2b, 32'h0000_1234, res_fault, dev_rom, 1'b0, 1'b1);
        add_entry(32'h0000_0040, 1'b1, acc_4b, 32'h0000_0000, res_fault, dev_rom, 1'b1, 1'b1);
        add_entry(32'h2000_0010, 1'b1, acc_4b, 32'h0000_0000, res_fault, dev_sram, 1'b0, 1'b0);
        add_entry(32'h2000_0010, 1'b1, acc_4b, 32'h0000_0000, res_ok, dev_sram, 1'b0, 1'b1);
        for (int i = 0; i < N_ENTRY; i++) begin
            run_entry(i);
        end
        repeat (2) @(negedge clk);
        total_err = err_count + uut.u_dispatch.u_asserts.fail_count;
        $display("entries %0d of %0d finished, %0d errors", done_count, N_ENTRY, total_err);
        if (done_count != N_ENTRY) begin
            $display("not every entry was closed by the checker");
        end
        if (total_err == 0 && done_count == N_ENTRY) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (N_ENTRY * 20) @(posedge clk);
        $display("watchdog expired before all entries finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

module target_model import bus_types_pkg::*; #(
    parameter addr_t BASE = '0
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  req,
    input  addr_t offset,
    input  int    delay,
    input  logic  raise_fault,
    output data_t rdata,
    output logic  resp,
    output logic  fault
);
    timeunit 1ns;
    timeprecision 1ps;

    data_t held;
    logic  held_fault;
    int    wait_cycles;

    initial begin
        rdata = '0;
        resp  = 1'b0;
        fault = 1'b0;
        forever begin
            @(posedge clk);
            if (rstn && req) begin
                held        = BASE ^ offset; // readback pattern
                held_fault  = raise_fault;
                wait_cycles = delay;
                repeat (wait_cycles) @(negedge clk);
                rdata = held;
                resp  = 1'b1;
                fault = held_fault;
                @(negedge clk);
                resp  = 1'b0;
                fault = 1'b0;
            end
        end
    end

endmodule

// ==== sources.f ====
logic/bus_types_pkg.sv
logic/bus_map_pkg.sv
logic/bus_decode_if.sv
logic/bus_addr_decode.sv
logic/bus_dispatch.sv
logic/bus_response.sv
logic/bus_fabric.sv
verif/bus_fabric_asserts.sv
verif/bus_fabric_checker.sv
verif/bus_fabric_tb.sv

// ==== Bender.yml ====
package:
  name: bus_fabric

sources:
  # packages first, then the interface and the three stages
  - logic/bus_types_pkg.sv
  - logic/bus_map_pkg.sv
  - logic/bus_decode_if.sv
  - logic/bus_addr_decode.sv
  - logic/bus_dispatch.sv
  - logic/bus_response.sv
  - logic/bus_fabric.sv

  - target: simulation
    files:
      - verif/bus_fabric_asserts.sv
      - verif/bus_fabric_checker.sv
      - verif/bus_fabric_tb.sv
